// ==== project.f ====
+incdir+dv
common/ctrl_pkg.sv
spi/spi_slave.sv
hdl/command_decoder.sv
pwm/pwm_channel.sv
hdl/frequency_counter.sv
hdl/signal_controller.sv
dv/signal_controller_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it; exit status reports pass or fail

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module signal_controller_tb -o signal_controller_sim &&
./obj_dir/signal_controller_sim || {
    echo "simulation did not pass"
    exit 1
}

// ==== dv/spi_host.svh ====
`ifndef spi_host_svh
`define spi_host_svh

localparam int sck_half_cycles = 4;  // sck toggles every 4 clk cycles
localparam int frame_gap_cycles = 8;

// tx is right-aligned with its first byte highest and rx fills the same way
task automatic spi_frame(input int nbytes, input logic [95:0] tx, output logic [95:0] rx);
    rx = '0;
    ncs = 1'b0;
    for (int i = nbytes * 8 - 1; i >= 0; i--) begin
        mosi = tx[i];  // set up while sck is low
        repeat (sck_half_cycles) @(posedge clk);
        #1;
        rx = {rx[94:0], miso};  // mode 0 sample point
        sck = 1'b1;
        repeat (sck_half_cycles) @(posedge clk);
        #1;
        sck = 1'b0;
    end
    repeat (sck_half_cycles) @(posedge clk);
    #1;
    ncs = 1'b1;  // frame ends here
    mosi = 1'b0;
endtask

task automatic frame_gap();
    repeat (frame_gap_cycles) @(posedge clk);
    #1;
endtask

`endif

// ==== dv/signal_controller_tb.sv ====
`timescale 1ns/1ps

module signal_controller_tb
    import ctrl_pkg::*;
();
    localparam int gate_cycles = 200;
    localparam int timeout_cycles = 20000;
    localparam int max_period = 36;
    localparam logic [95:0] query_id = 96'({op_get_id, 8'd0});
    localparam logic [95:0] query_result = 96'({op_get_result, 8'd0});
    localparam logic [95:0] id_reply = {id_bytes, 64'd0};
    // little-endian codes with channel 0 first
    localparam logic [95:0] result_reply = {8'(gate_cycles / 10), 24'd0,
                                            8'(gate_cycles / 25), 24'd0, 32'd0};

    logic clk;
    logic nreset;
    logic sck;
    logic ncs;
    logic mosi;
    wire miso;
    logic interrupt;
    logic [3:0] pwm_out;
    logic [1:0] freq_in;
    integer seed;
    int cycles = 0;
    int fdiv;
    logic [95:0] rx;
    int ch_a;
    int ch_b;
    int per_a;
    int per_b;
    int duty_a;
    int duty_b;

    `include "spi_host.svh"

    signal_controller #(
        .gate_cycles (gate_cycles)
    ) signal_controller_i (
        .clk       (clk),
        .nreset    (nreset),
        .sck       (sck),
        .ncs       (ncs),
        .mosi      (mosi),
        .miso      (miso),
        .interrupt (interrupt),
        .pwm_out   (pwm_out),
        .freq_in   (freq_in)
    );

    task automatic fail_run(input string reason);
        $display("TEST FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string name, input logic [95:0] expected,
                               input logic [95:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            fail_run("value mismatch");
        end
    endtask

    function automatic logic [31:0] le32(input logic [31:0] v);
        return {v[7:0], v[15:8], v[23:16], v[31:24]};
    endfunction

    task automatic send_set(input int ch, input logic [7:0] cls, input int period,
                            input int duty);
        spi_frame(12, {8'd0, cls, op_set_period_duty, 8'(ch), le32(period), le32(duty)}, rx);
        frame_gap();
    endtask

    task automatic send_enable(input int ch, input logic [7:0] op, input logic [7:0] en);
        spi_frame(5, {56'd0, 8'd0, class_pwm, op, 8'(ch), en}, rx);
        frame_gap();
    endtask

    // settle past the old period, then count highs over one new period
    task automatic check_duty(input int ch, input int period, input int duty);
        int highs;
        highs = 0;
        repeat (2 * max_period) @(posedge clk);
        repeat (period) begin
            @(posedge clk);
            #1;
            highs += int'(pwm_out[ch]);
        end
        check_value($sformatf("pwm_out[%0d] high cycles", ch), duty, highs);
    endtask

    task automatic wait_interrupt(input int limit);
        int n;
        n = 0;
        while (!interrupt && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        assert (interrupt) else fail_run("interrupt did not rise after a gate window");
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        freq_in = 2'b00;
        fdiv = 0;
        forever begin
            @(posedge clk);
            #1;
            fdiv++;
            freq_in[0] = (fdiv % 10) < 5;
            freq_in[1] = (fdiv % 25) < 12;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles) begin
            fail_run("timeout, the run did not finish in time");
        end
    end

    always @(posedge clk) begin
        if (ncs) begin
            assert (miso === 1'bz) else begin
                $display("[ERROR] miso: expected z, actual %h while ncs high", miso);
                fail_run("miso driven while deselected");
            end
        end
    end

    initial begin
        seed = 32'h3b32e066;
        nreset = 1'b0;
        sck = 1'b0;
        ncs = 1'b1;
        mosi = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        nreset = 1'b1;

        repeat (20) begin
            @(posedge clk);
            #1;
            check_value("interrupt", 0, interrupt);
            check_value("pwm_out", 0, pwm_out);
        end

        spi_frame(2, query_id, rx);
        frame_gap();
        spi_frame(12, '0, rx);
        frame_gap();
        check_value("miso reply to get_id", id_reply, rx);

        ch_a = $unsigned($random(seed)) % 4;
        ch_b = (ch_a + 1 + $unsigned($random(seed)) % 3) % 4;
        per_a = 4 + $unsigned($random(seed)) % 32;
        per_b = 4 + $unsigned($random(seed)) % 32;
        duty_a = 1 + $unsigned($random(seed)) % (per_a - 1);
        duty_b = 1 + $unsigned($random(seed)) % (per_b - 1);

        send_set(ch_a, class_pwm, per_a, duty_a);
        check_duty(ch_a, per_a, 0);  // still disabled
        send_enable(ch_a, op_enable_output, 8'd1);
        check_duty(ch_a, per_a, duty_a);
        send_set(ch_b, class_pwm, per_b, duty_b);
        send_enable(ch_b, op_enable_output, 8'd1);
        check_duty(ch_b, per_b, duty_b);

        send_enable(ch_a, op_enable_output, 8'd0);
        check_duty(ch_a, per_a, 0);
        check_duty(ch_b, per_b, duty_b);
        send_enable(ch_a, op_enable_output, 8'd1);
        check_duty(ch_a, per_a, duty_a);

        // rejected frames after a nonzero reply
        spi_frame(2, query_id, rx);
        frame_gap();
        send_set(ch_b, class_pwm + 8'd1, per_a, duty_a);
        check_value("miso reply to get_id", id_reply, rx);
        send_enable(ch_b, op_enable_output + 8'd1, 8'd0);
        check_value("miso reply to wrong class", 0, rx);
        // disable bytes for ch_b in a 6-byte frame
        spi_frame(6, 96'({8'd0, 8'd0, class_pwm, op_enable_output, 8'(ch_b), 8'd0}), rx);
        frame_gap();
        check_value("miso reply to wrong opcode", 0, rx);
        spi_frame(12, '0, rx);
        frame_gap();
        check_value("miso reply to 6-byte frame", 0, rx);
        check_duty(ch_a, per_a, duty_a);
        check_duty(ch_b, per_b, duty_b);

        // drop stale results so the next rise starts a known window
        repeat (3) begin
            if (interrupt) begin
                spi_frame(2, query_result, rx);
                frame_gap();
            end
        end
        check_value("interrupt after clearing", 0, interrupt);
        wait_interrupt(2 * gate_cycles);
        spi_frame(2, query_result, rx);
        repeat (3) @(posedge clk);
        #1;
        check_value("interrupt 3 cycles after ncs rise", 1, interrupt);
        @(posedge clk);
        #1;
        check_value("interrupt 4 cycles after ncs rise", 0, interrupt);
        wait_interrupt(2 * gate_cycles);
        frame_gap();
        spi_frame(12, '0, rx);
        frame_gap();
        check_value("miso reply to get_result", result_reply, rx);

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== hdl/signal_controller.sv ====
`timescale 1ns/1ps

module signal_controller
    import ctrl_pkg::*;
#(
    parameter int pwm_channels = 4,
    parameter int fc_channels = 2,
    parameter int gate_cycles = 27000000,
    parameter int cnt_width = 32
) (
    input  logic                    clk,
    input  logic                    nreset,
    input  logic                    sck,
    input  logic                    ncs,
    input  logic                    mosi,
    output wire                     miso,
    output logic                    interrupt,
    output logic [pwm_channels-1:0] pwm_out,
    input  logic [fc_channels-1:0]  freq_in
);
    command_u command;
    logic [3:0] byte_count;
    logic frame_done;
    logic response_load;
    logic [frame_bits-1:0] response;
    logic result_clear;
    logic [pwm_channels-1:0][31:0] period;
    logic [pwm_channels-1:0][31:0] duty;
    logic [fc_channels-1:0][cnt_width-1:0] codes;
    logic [fc_channels-1:0] ready;

    assign interrupt = &ready;  // all counters hold a fresh result

    spi_slave spi_slave_i (
        .clk           (clk),
        .nreset        (nreset),
        .sck           (sck),
        .ncs           (ncs),
        .mosi          (mosi),
        .miso          (miso),
        .command       (command),
        .byte_count    (byte_count),
        .frame_done    (frame_done),
        .response_load (response_load),
        .response      (response)
    );

    command_decoder #(
        .pwm_channels (pwm_channels),
        .fc_channels  (fc_channels),
        .cnt_width    (cnt_width)
    ) command_decoder_i (
        .clk           (clk),
        .nreset        (nreset),
        .command       (command),
        .byte_count    (byte_count),
        .frame_done    (frame_done),
        .codes         (codes),
        .response_load (response_load),
        .response      (response),
        .result_clear  (result_clear),
        .period        (period),
        .duty          (duty)
    );

    for (genvar k = 0; k < pwm_channels; k++) begin : g_pwm
        pwm_channel pwm_channel_i (
            .clk    (clk),
            .nreset (nreset),
            .period (period[k]),
            .duty   (duty[k]),
            .out    (pwm_out[k])
        );
    end

    for (genvar k = 0; k < fc_channels; k++) begin : g_fc
        frequency_counter #(
            .gate_cycles (gate_cycles),
            .cnt_width   (cnt_width)
        ) frequency_counter_i (
            .clk          (clk),
            .nreset       (nreset),
            .freq_in      (freq_in[k]),
            .result_clear (result_clear),
            .code         (codes[k]),
            .ready        (ready[k])
        );
    end

endmodule

// ==== hdl/frequency_counter.sv ====
`timescale 1ns/1ps

module frequency_counter #(
    parameter int gate_cycles = 27000000,
    parameter int cnt_width = 32
) (
    input  logic                 clk,
    input  logic                 nreset,
    input  logic                 freq_in,
    input  logic                 result_clear,
    output logic [cnt_width-1:0] code,
    output logic                 ready
);
    localparam int gate_width = $clog2(gate_cycles);

    logic [2:0] freq_sync;  // two sync stages plus history
    logic freq_rise;
    logic gate_end;
    logic [gate_width-1:0] gate_count;
    logic [cnt_width-1:0] edge_count;

    assign freq_rise = freq_sync[1] & ~freq_sync[2];
    assign gate_end = gate_count == gate_width'(gate_cycles - 1);

    always_ff @(posedge clk) begin
        if (!nreset) begin
            freq_sync <= '0;
            gate_count <= '0;
            edge_count <= '0;
            ready <= 1'b0;
        end else begin
            freq_sync <= {freq_sync[1:0], freq_in};
            if (gate_end) begin
                gate_count <= '0;
                edge_count <= '0;
            end else begin
                gate_count <= gate_count + 1'b1;
                if (freq_rise) begin
                    edge_count <= edge_count + 1'b1;
                end
            end

            if (gate_end) begin
                ready <= 1'b1;  // fresh result wins over a clear
            end else if (result_clear) begin
                ready <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (gate_end) begin
            code <= edge_count + cnt_width'(freq_rise);  // include last cycle's edge
        end
    end

endmodule

// ==== pwm/pwm_channel.sv ====
`timescale 1ns/1ps

module pwm_channel (
    input  logic        clk,
    input  logic        nreset,
    input  logic [31:0] period,
    input  logic [31:0] duty,
    output logic        out
);
    logic [31:0] count;
    logic [31:0] period_q;
    logic [31:0] duty_q;
    logic wrap;

    // period of 0 or 1 wraps every cycle
    assign wrap = period_q <= 32'd1 || count == period_q - 32'd1;

    assign out = count < duty_q;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            count <= '0;
            period_q <= 32'd1;
            duty_q <= '0;
        end else if (wrap) begin
            count <= '0;
            period_q <= period;  // new settings only at the wrap
            duty_q <= duty;
        end else begin
            count <= count + 32'd1;
        end
    end

endmodule

// ==== hdl/command_decoder.sv ====
`timescale 1ns/1ps

module command_decoder
    import ctrl_pkg::*;
#(
    parameter int pwm_channels = 4,
    parameter int fc_channels = 2,
    parameter int cnt_width = 32
) (
    input  logic                                  clk,
    input  logic                                  nreset,
    input  command_u                              command,
    input  logic [3:0]                            byte_count,
    input  logic                                  frame_done,
    input  logic [fc_channels-1:0][cnt_width-1:0] codes,
    output logic                                  response_load,
    output logic [frame_bits-1:0]                 response,
    output logic                                  result_clear,
    output logic [pwm_channels-1:0][31:0]         period,
    output logic [pwm_channels-1:0][31:0]         duty
);
    logic [pwm_channels-1:0][31:0] duty_bak;
    logic [pwm_channels-1:0] enabled;
    logic [7:0] query_op;
    logic is_query;
    logic set_hit;
    logic enable_hit;
    logic [frame_bits-1:0] result_word;

    function automatic logic [31:0] swap32(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    assign query_op = command[15:8];  // first byte of a query
    assign is_query = frame_done && byte_count == cmd_query_bytes;

    assign set_hit = frame_done && byte_count == cmd_set_bytes
                     && command.set_view.class_id == class_pwm
                     && command.set_view.opcode == op_set_period_duty;

    assign enable_hit = frame_done && byte_count == cmd_enable_bytes
                        && command.enable_view.class_id == class_pwm
                        && command.enable_view.opcode == op_enable_output;

    // counters drop ready on the same edge the reply is captured
    assign result_clear = is_query && query_op == op_get_result;

    always_comb begin
        result_word = '0;
        for (int k = 0; k < fc_channels; k++) begin
            for (int b = 0; b < cnt_width / 8; b++) begin
                result_word[frame_bits - 1 - k * cnt_width - b * 8 -: 8] = codes[k][b * 8 +: 8];
            end
        end
    end

    always_comb begin
        for (int k = 0; k < pwm_channels; k++) begin
            duty[k] = enabled[k] ? duty_bak[k] : 32'd0;  // disabled channel stays low
        end
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            response_load <= 1'b0;
            enabled <= '0;
            for (int k = 0; k < pwm_channels; k++) begin
                period[k] <= 32'd1;
                duty_bak[k] <= 32'd0;
            end
        end else begin
            response_load <= frame_done;  // every frame gets a reply
            for (int k = 0; k < pwm_channels; k++) begin
                if (set_hit && command.set_view.channel == 8'(k)) begin
                    period[k] <= swap32(command.set_view.period);
                    duty_bak[k] <= swap32(command.set_view.duty);
                end
                if (enable_hit && command.enable_view.channel == 8'(k)) begin
                    enabled[k] <= command.enable_view.enable != 8'd0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_done) begin
            if (is_query && query_op == op_get_id) begin
                response <= {id_bytes, {(frame_bits - 32){1'b0}}};
            end else if (result_clear) begin
                response <= result_word;
            end else begin
                response <= '0;  // writes, status and unknown frames
            end
        end
    end

endmodule

// ==== spi/spi_slave.sv ====
`timescale 1ns/1ps

module spi_slave
    import ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  nreset,
    input  logic                  sck,
    input  logic                  ncs,
    input  logic                  mosi,
    output wire                   miso,
    output command_u              command,
    output logic [3:0]            byte_count,
    output logic                  frame_done,
    input  logic                  response_load,
    input  logic [frame_bits-1:0] response
);
    logic [2:0] sck_sync;  // two sync stages plus history
    logic [2:0] ncs_sync;
    logic [1:0] mosi_sync;
    logic sck_rise;
    logic sck_fall;
    logic ncs_rise;
    logic ncs_fall;
    logic selected;
    logic [6:0] bit_count;
    logic [frame_bits-1:0] shift_in;
    logic [frame_bits-1:0] shift_out;

    assign sck_rise = sck_sync[1] & ~sck_sync[2];
    assign sck_fall = ~sck_sync[1] & sck_sync[2];
    assign ncs_rise = ncs_sync[1] & ~ncs_sync[2];
    assign ncs_fall = ~ncs_sync[1] & ncs_sync[2];
    assign selected = ~ncs_sync[1];

    assign command = shift_in;
    assign byte_count = bit_count[6:3];
    assign miso = ncs ? 1'bz : shift_out[frame_bits-1];

    always_ff @(posedge clk) begin
        if (!nreset) begin
            sck_sync <= 3'b000;
            ncs_sync <= 3'b111;
            mosi_sync <= 2'b00;
            bit_count <= '0;
            frame_done <= 1'b0;
            shift_out <= '0;
        end else begin
            sck_sync <= {sck_sync[1:0], sck};
            ncs_sync <= {ncs_sync[1:0], ncs};
            mosi_sync <= {mosi_sync[0], mosi};
            frame_done <= ncs_rise;  // 3 cycles after ncs goes high

            if (ncs_fall) begin
                bit_count <= '0;
            end else if (selected && sck_rise && bit_count != '1) begin
                bit_count <= bit_count + 7'd1;  // saturates on overlong frames
            end

            if (response_load) begin
                shift_out <= response;
            end else if (selected && sck_fall) begin
                shift_out <= {shift_out[frame_bits-2:0], 1'b0};  // msb first
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ncs_fall) begin
            shift_in <= '0;
        end else if (selected && sck_rise) begin
            shift_in <= {shift_in[frame_bits-2:0], mosi_sync[1]};
        end
    end

endmodule

// ==== common/ctrl_pkg.sv ====
package ctrl_pkg;

    localparam int frame_bits = 96;  // 12 bytes

    // frame lengths in bytes
    localparam logic [3:0] cmd_query_bytes = 4'd2;
    localparam logic [3:0] cmd_enable_bytes = 4'd5;
    localparam logic [3:0] cmd_set_bytes = 4'd12;

    localparam logic [7:0] op_get_id = 8'd0;
    localparam logic [7:0] op_get_result = 8'd4;

    localparam logic [7:0] class_pwm = 8'd3;
    localparam logic [7:0] op_set_period_duty = 8'd2;
    localparam logic [7:0] op_enable_output = 8'd5;

    localparam logic [3:0][7:0] id_bytes = '{8'h01, 8'h04, 8'h02, 8'h00};  // msb first

    typedef struct packed {
        logic [7:0]  subdevice;
        logic [7:0]  class_id;
        logic [7:0]  opcode;
        logic [7:0]  channel;
        logic [31:0] period;  // little-endian on the wire
        logic [31:0] duty;    // little-endian on the wire
    } pwm_set_frame_t;

    typedef struct packed {
        logic [55:0] pad;  // right-aligned short frame
        logic [7:0]  subdevice;
        logic [7:0]  class_id;
        logic [7:0]  opcode;
        logic [7:0]  channel;
        logic [7:0]  enable;
    } pwm_enable_frame_t;

    typedef union packed {
        pwm_set_frame_t    set_view;
        pwm_enable_frame_t enable_view;
    } command_u;

endpackage
